// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FILELIST  ?= decode_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== decode_stage.f ====
+incdir+rtl
rtl/decode_pkg.sv
rtl/main_decoder.sv
rtl/alu_decoder.sv
rtl/imm_extend.sv
rtl/decode_bundle_reg.sv
rtl/decode_stage.sv
dv/decode_stage_checker.sv
dv/decode_stage_tb.sv

// ==== dv/decode_stage_checker.sv ====
`default_nettype none

module decode_stage_checker (
    input logic                clk_i,
    input logic                arst_n_i,
    input logic                flush_i,
    input decode_pkg::bundle_t bundle_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // First cycle out of reset carries nothing
    property p_reset_clean;
        @(posedge clk_i) $rose(arst_n_i) |-> bundle_i == '0;
    endproperty

    property p_flush_kills;
        @(posedge clk_i) disable iff (!arst_n_i)
            flush_i |=> !bundle_i.valid && !bundle_i.ctrl.reg_write
                        && !bundle_i.ctrl.mem_write;
    endproperty

    property p_illegal_no_write;
        @(posedge clk_i) disable iff (!arst_n_i)
            bundle_i.illegal |-> !bundle_i.ctrl.reg_write && !bundle_i.ctrl.mem_write;
    endproperty

    // A store never loads its result
    property p_store_not_mem;
        @(posedge clk_i) disable iff (!arst_n_i)
            bundle_i.ctrl.mem_write |-> bundle_i.ctrl.result_src != decode_pkg::RES_MEM;
    endproperty

    a_reset_clean: assert property (p_reset_clean)
        else $error("bundle not cleared after reset release");
    a_flush_kills: assert property (p_flush_kills)
        else $error("bundle still valid or writing after a flush");
    a_illegal_no_write: assert property (p_illegal_no_write)
        else $error("illegal instruction has a write enable set");
    a_store_not_mem: assert property (p_store_not_mem)
        else $error("memory write with memory result select");

endmodule

bind decode_stage decode_stage_checker u_checker (
    .clk_i    (clk),
    .arst_n_i (arst_n_i),
    .flush_i  (flush_i),
    .bundle_i (bundle_o)
);

`default_nettype wire

// ==== dv/decode_stage_tb.sv ====
`default_nettype none

`include "decode_cfg.svh"

module decode_stage_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam time              CLK_PERIOD = 40ns;
    localparam string            DATA_FILE  = "dv/decode_stage_testdata.txt";
    // addi x0, x0, 0
    localparam logic [`XLEN-1:0] IDLE_INSTR = 32'h0000_0013;

    logic                clk;
    logic                arst_n;
    logic [`XLEN-1:0]    instr;
    logic                valid;
    logic                flush;
    decode_pkg::bundle_t bundle;

    // Vectors from the data file
    string               name_q[$];
    logic [`XLEN-1:0]    instr_q[$];
    logic                valid_q[$];
    logic                flush_q[$];
    decode_pkg::bundle_t expect_q[$];

    int pass_cnt;
    int fail_cnt;
    bit loaded;

    decode_stage u_dut (
        .clk      (clk),
        .arst_n_i (arst_n),
        .instr_i  (instr),
        .valid_i  (valid),
        .flush_i  (flush),
        .bundle_o (bundle)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic load_vectors(output bit ok);
        int                  fd;
        int                  cnt;
        bit                  bad;
        string               line;
        string               name;
        logic [`XLEN-1:0]    ins;
        logic [`XLEN-1:0]    imm;
        int                  col[14];
        decode_pkg::bundle_t exp_b;

        bad = 1'b0;
        fd  = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("cannot open test data file %s", DATA_FILE);
            bad = 1'b1;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[0] == "#") begin
                    continue;
                end
                cnt = $sscanf(line, "%s %h %d %d %d %d %d %d %d %d %d %d %d %d %d %d %h",
                              name, ins, col[0], col[1], col[2], col[3], col[4], col[5],
                              col[6], col[7], col[8], col[9], col[10], col[11], col[12],
                              col[13], imm);
                if (cnt == 17) begin
                    exp_b                 = '0;
                    exp_b.valid           = col[2][0];
                    exp_b.illegal         = col[3][0];
                    exp_b.ctrl.reg_write  = col[4][0];
                    exp_b.ctrl.imm_src    = decode_pkg::imm_src_e'(col[5][2:0]);
                    exp_b.ctrl.alu_src    = col[6][0];
                    exp_b.ctrl.mem_write  = col[7][0];
                    exp_b.ctrl.result_src = decode_pkg::result_src_e'(col[8][2:0]);
                    exp_b.ctrl.branch_op  = decode_pkg::branch_op_e'(col[9][1:0]);
                    exp_b.ctrl.alu_op     = decode_pkg::alu_op_e'(col[10][1:0]);
                    exp_b.ctrl.width_op   = col[11][0];
                    exp_b.ctrl.pc_base    = decode_pkg::pc_base_e'(col[12][1:0]);
                    exp_b.alu_ctrl        = col[13][`ALU_CTRL_W-1:0];
                    exp_b.imm             = imm;
                    // Register fields at their fixed RV32I bit positions
                    exp_b.rd              = ins[11:7];
                    exp_b.rs1             = ins[19:15];
                    exp_b.rs2             = ins[24:20];
                    exp_b.funct3          = ins[14:12];
                    name_q.push_back(name);
                    instr_q.push_back(ins);
                    valid_q.push_back(col[0][0]);
                    flush_q.push_back(col[1][0]);
                    expect_q.push_back(exp_b);
                end else if (cnt > 0) begin
                    $display("malformed line in test data: %s", line);
                    bad = 1'b1;
                end
            end
            $fclose(fd);
        end
        ok = !bad && (name_q.size() > 0);
    endtask

    task automatic check_bundle(input string name, input decode_pkg::bundle_t expected);
        assert (bundle === expected) begin
            pass_cnt++;
            $display("ok    %s", name);
        end else begin
            fail_cnt++;
            $display("error %s: expected %h actual %h", name, expected, bundle);
        end
    endtask

    task automatic apply_reset();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    // Vector i goes in on one edge and is checked after the next
    task automatic run_vectors();
        for (int i = 0; i <= name_q.size(); i++) begin
            @(posedge clk);
            if (i < name_q.size()) begin
                instr <= instr_q[i];
                valid <= valid_q[i];
                flush <= flush_q[i];
            end else begin
                instr <= IDLE_INSTR;
                valid <= 1'b0;
                flush <= 1'b0;
            end
            @(negedge clk);
            if (i > 0) begin
                check_bundle(name_q[i-1], expect_q[i-1]);
            end
        end
    endtask

    initial begin
        bit load_ok;

        arst_n   = 1'b0;
        instr    = IDLE_INSTR;
        valid    = 1'b0;
        flush    = 1'b0;
        pass_cnt = 0;
        fail_cnt = 0;
        loaded   = 1'b0;
        load_vectors(load_ok);
        loaded = 1'b1;
        if (load_ok) begin
            apply_reset();
            @(negedge clk);
            check_bundle("reset", '0);
            run_vectors();
        end else begin
            $display("no usable test vectors in %s", DATA_FILE);
            fail_cnt++;
        end
        $display("tests: %0d, passed: %0d, failed: %0d", pass_cnt + fail_cnt, pass_cnt,
                 fail_cnt);
        if (fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Vectors plus reset and drain, with margin
    initial begin
        wait (loaded);
        #((name_q.size() + 10) * CLK_PERIOD);
        $display("watchdog timeout, the run did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/decode_stage_testdata.txt ====
# name instr valid flush | expected: valid illegal reg_write imm_src alu_src mem_write
# result_src branch_op alu_op width_op pc_base alu_ctrl imm (instr and imm in hex)
r_add            002081B3 1 0  1 0  1 0 0 0 0 0 2 0 0  0 00000000
r_sub            407302B3 1 0  1 0  1 0 0 0 0 0 2 0 0  1 00000000
r_sll            00A49433 1 0  1 0  1 0 0 0 0 0 2 0 0  2 00000000
r_slt            003120B3 1 0  1 0  1 0 0 0 0 0 2 0 0  3 00000000
r_sltu           003130B3 1 0  1 0  1 0 0 0 0 0 2 0 0  4 00000000
r_xor            003140B3 1 0  1 0  1 0 0 0 0 0 2 0 0  5 00000000
r_srl            003150B3 1 0  1 0  1 0 0 0 0 0 2 0 0  6 00000000
r_sra            403150B3 1 0  1 0  1 0 0 0 0 0 2 0 0  7 00000000
r_or             003160B3 1 0  1 0  1 0 0 0 0 0 2 0 0  8 00000000
r_and            003170B3 1 0  1 0  1 0 0 0 0 0 2 0 0  9 00000000
i_addi_neg       FFB08213 1 0  1 0  1 1 1 0 0 0 2 0 0  0 FFFFFFFB
i_slti           0641A113 1 0  1 0  1 1 1 0 0 0 2 0 0  3 00000064
i_sltiu          FFF1B113 1 0  1 0  1 1 1 0 0 0 2 0 0  4 FFFFFFFF
i_xori           0F01C113 1 0  1 0  1 1 1 0 0 0 2 0 0  5 000000F0
i_ori            7FF1E113 1 0  1 0  1 1 1 0 0 0 2 0 0  8 000007FF
i_andi           F001F113 1 0  1 0  1 1 1 0 0 0 2 0 0  9 FFFFFF00
i_slli           00419113 1 0  1 0  1 1 1 0 0 0 2 0 0  2 00000004
i_srli           0041D113 1 0  1 0  1 1 1 0 0 0 2 0 0  6 00000004
i_srai           4041D113 1 0  1 0  1 1 1 0 0 0 2 0 0  7 00000404
load_lw_neg      FF812303 1 0  1 0  1 1 1 0 1 0 0 1 0  0 FFFFFFF8
store_sw_neg     FE512A23 1 0  1 0  0 2 1 1 0 0 0 1 0  0 FFFFFFF4
store_sb_pos     027082A3 1 0  1 0  0 2 1 1 0 0 0 1 0  0 00000025
beq_neg          FE2088E3 1 0  1 0  0 3 0 0 0 1 1 0 1  1 FFFFFFF0
bne_pos          004190E3 1 0  1 0  0 3 0 0 0 1 1 0 1  1 00000800
jal_neg          FFDFF0EF 1 0  1 0  1 4 0 0 2 2 3 0 1  0 FFFFFFFC
jal_pos          4DFAB2EF 1 0  1 0  1 4 0 0 2 2 3 0 1  0 000ABCDE
jalr_pos         010280E7 1 0  1 0  1 1 0 0 2 2 3 0 2  0 00000010
lui_neg          ABCDE3B7 1 0  1 0  1 5 0 0 3 0 3 0 0  0 ABCDE000
auipc_pos        12345497 1 0  1 0  1 5 0 0 4 0 3 0 1  0 12345000
sys_ecall        00000073 1 0  1 1  0 0 0 0 0 0 0 0 0  0 00000000
fence            0000000F 1 0  1 1  0 0 0 0 0 0 0 0 0  0 00000000
gate_valid_low   002081B3 0 0  0 0  0 0 0 0 0 0 2 0 0  0 00000000
gate_flush_sw    FE512A23 1 1  0 0  0 2 1 0 0 0 0 1 0  0 FFFFFFF4
gate_flush_beq   FE2088E3 1 1  0 0  0 3 0 0 0 0 1 0 1  1 FFFFFFF0
gate_jal_invalid FFDFF0EF 0 0  0 0  0 4 0 0 2 0 3 0 1  0 FFFFFFFC
gate_flush_ecall 00000073 1 1  0 1  0 0 0 0 0 0 0 0 0  0 00000000
post_flush_add   002081B3 1 0  1 0  1 0 0 0 0 0 2 0 0  0 00000000

// ==== rtl/alu_decoder.sv ====
`default_nettype none

`include "decode_cfg.svh"

module alu_decoder (
    input  decode_pkg::alu_op_e     alu_op_i,
    input  logic [2:0]              funct3_i,
    input  logic                    funct7_5_i,
    input  logic                    op_5_i,
    output logic [`ALU_CTRL_W-1:0]  alu_ctrl_o
);

    logic is_sub;

    // Only R-type has opcode bit 5 set among the ALU classes
    assign is_sub = op_5_i & funct7_5_i;

    always_comb begin
        case (alu_op_i)
            decode_pkg::ALU_OP_ADD: alu_ctrl_o = `ALU_ADD;
            decode_pkg::ALU_OP_SUB: alu_ctrl_o = `ALU_SUB;
            decode_pkg::ALU_OP_PROCESS: begin
                case (funct3_i)
                    3'b000:  alu_ctrl_o = is_sub ? `ALU_SUB : `ALU_ADD;
                    3'b001:  alu_ctrl_o = `ALU_SLL;
                    3'b010:  alu_ctrl_o = `ALU_SLT;
                    3'b011:  alu_ctrl_o = `ALU_SLTU;
                    3'b100:  alu_ctrl_o = `ALU_XOR;
                    // srai also carries bit 30, so no opcode check here
                    3'b101:  alu_ctrl_o = funct7_5_i ? `ALU_SRA : `ALU_SRL;
                    3'b110:  alu_ctrl_o = `ALU_OR;
                    default: alu_ctrl_o = `ALU_AND;
                endcase
            end
            // ALU unused by the instruction
            default: alu_ctrl_o = `ALU_ADD;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/decode_bundle_reg.sv ====
`default_nettype none

`include "decode_cfg.svh"

module decode_bundle_reg (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    valid_i,
    input  logic                    flush_i,
    input  logic                    illegal_i,
    input  decode_pkg::ctrl_t       ctrl_i,
    input  logic [`ALU_CTRL_W-1:0]  alu_ctrl_i,
    input  logic [`XLEN-1:0]        imm_i,
    input  decode_pkg::instr_u      instr_i,
    output decode_pkg::bundle_t     bundle_o
);

    logic                live;
    decode_pkg::bundle_t bundle_d;

    assign live = valid_i & ~flush_i;

    always_comb begin
        bundle_d          = '0;
        bundle_d.valid    = live;
        bundle_d.illegal  = illegal_i;
        bundle_d.ctrl     = ctrl_i;
        bundle_d.alu_ctrl = alu_ctrl_i;
        bundle_d.imm      = imm_i;
        // Register fields sit at the same place in every format
        bundle_d.rd       = instr_i.r.rd;
        bundle_d.rs1      = instr_i.r.rs1;
        bundle_d.rs2      = instr_i.r.rs2;
        bundle_d.funct3   = instr_i.r.funct3;

        // Kill anything with an architectural side effect
        bundle_d.ctrl.reg_write = ctrl_i.reg_write & live;
        bundle_d.ctrl.mem_write = ctrl_i.mem_write & live;
        if (!live) begin
            bundle_d.ctrl.branch_op = decode_pkg::BR_NONE;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bundle_o <= `BUNDLE_RST_VAL;
        end else begin
            bundle_o <= bundle_d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/decode_cfg.svh ====
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// Datapath width
`define XLEN 32

// Base opcodes handled by the main decoder
`define OP_R      7'b0110011
`define OP_I_ALU  7'b0010011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111

// ALU control width and codes
`define ALU_CTRL_W 4
`define ALU_ADD  4'b0000
`define ALU_SUB  4'b0001
`define ALU_SLL  4'b0010
`define ALU_SLT  4'b0011
`define ALU_SLTU 4'b0100
`define ALU_XOR  4'b0101
`define ALU_SRL  4'b0110
`define ALU_SRA  4'b0111
`define ALU_OR   4'b1000
`define ALU_AND  4'b1001

// Bundle value out of reset, everything inactive
`define BUNDLE_RST_VAL '0

`endif

// ==== rtl/decode_pkg.sv ====
`default_nettype none

`include "decode_cfg.svh"

package decode_pkg;

    // Instruction layouts, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // Same 32 bits seen through every format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_J    = 3'd4,
        IMM_U    = 3'd5
    } imm_src_e;

    typedef enum logic [2:0] {
        RES_ALU       = 3'd0,
        RES_MEM       = 3'd1,
        RES_PC_PLUS4  = 3'd2,
        RES_IMM       = 3'd3,
        RES_PC_TARGET = 3'd4
    } result_src_e;

    typedef enum logic [1:0] {
        ALU_OP_ADD     = 2'd0,
        ALU_OP_SUB     = 2'd1,
        ALU_OP_PROCESS = 2'd2,
        ALU_OP_NA      = 2'd3
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        BR_BRANCH = 2'd1,
        BR_JUMP   = 2'd2
    } branch_op_e;

    typedef enum logic [1:0] {
        PC_BASE_NA   = 2'd0,
        PC_BASE_PC   = 2'd1,
        PC_BASE_SRCA = 2'd2
    } pc_base_e;

    // Main decoder output
    typedef struct packed {
        logic        reg_write;
        imm_src_e    imm_src;
        logic        alu_src;
        logic        mem_write;
        result_src_e result_src;
        branch_op_e  branch_op;
        alu_op_e     alu_op;
        logic        width_op;
        pc_base_e    pc_base;
    } ctrl_t;

    // Decode-to-execute boundary
    typedef struct packed {
        logic                   valid;
        logic                   illegal;
        ctrl_t                  ctrl;
        logic [`ALU_CTRL_W-1:0] alu_ctrl;
        logic [`XLEN-1:0]       imm;
        logic [4:0]             rd;
        logic [4:0]             rs1;
        logic [4:0]             rs2;
        logic [2:0]             funct3;
    } bundle_t;

endpackage

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`default_nettype none

`include "decode_cfg.svh"

module decode_stage (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic [`XLEN-1:0]    instr_i,
    input  logic                valid_i,
    input  logic                flush_i,
    output decode_pkg::bundle_t bundle_o
);

    decode_pkg::instr_u     instr;
    decode_pkg::ctrl_t      ctrl;
    logic                   illegal;
    logic [`ALU_CTRL_W-1:0] alu_ctrl;
    logic [`XLEN-1:0]       imm;

    assign instr = instr_i;

    main_decoder u_main_decoder (
        .op_i      (instr.r.opcode),
        .ctrl_o    (ctrl),
        .illegal_o (illegal)
    );

    alu_decoder u_alu_decoder (
        .alu_op_i   (ctrl.alu_op),
        .funct3_i   (instr.r.funct3),
        .funct7_5_i (instr.r.funct7[5]),
        .op_5_i     (instr.r.opcode[5]),
        .alu_ctrl_o (alu_ctrl)
    );

    imm_extend u_imm_extend (
        .instr_i   (instr),
        .imm_src_i (ctrl.imm_src),
        .imm_o     (imm)
    );

    decode_bundle_reg u_bundle_reg (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .valid_i    (valid_i),
        .flush_i    (flush_i),
        .illegal_i  (illegal),
        .ctrl_i     (ctrl),
        .alu_ctrl_i (alu_ctrl),
        .imm_i      (imm),
        .instr_i    (instr),
        .bundle_o   (bundle_o)
    );

endmodule

`default_nettype wire

// ==== rtl/imm_extend.sv ====
`default_nettype none

`include "decode_cfg.svh"

module imm_extend (
    input  decode_pkg::instr_u   instr_i,
    input  decode_pkg::imm_src_e imm_src_i,
    output logic [`XLEN-1:0]     imm_o
);

    // Every format keeps its sign in instruction bit 31
    always_comb begin
        case (imm_src_i)
            decode_pkg::IMM_I: begin
                imm_o = {{20{instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
            end
            decode_pkg::IMM_S: begin
                imm_o = {{20{instr_i.s.imm_11_5[6]}},
                         instr_i.s.imm_11_5,
                         instr_i.s.imm_4_0};
            end
            // Branch offsets are in halfwords
            decode_pkg::IMM_B: begin
                imm_o = {{19{instr_i.b.imm_12}},
                         instr_i.b.imm_12,
                         instr_i.b.imm_11,
                         instr_i.b.imm_10_5,
                         instr_i.b.imm_4_1,
                         1'b0};
            end
            decode_pkg::IMM_J: begin
                imm_o = {{11{instr_i.j.imm_20}},
                         instr_i.j.imm_20,
                         instr_i.j.imm_19_12,
                         instr_i.j.imm_11,
                         instr_i.j.imm_10_1,
                         1'b0};
            end
            // Upper 20 bits, low 12 zero
            decode_pkg::IMM_U: begin
                imm_o = {instr_i.u.imm_31_12, 12'b0};
            end
            default: imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/main_decoder.sv ====
`default_nettype none

`include "decode_cfg.svh"

module main_decoder (
    input  logic [6:0]        op_i,
    output decode_pkg::ctrl_t ctrl_o,
    output logic              illegal_o
);

    // Field order: reg_write, imm_src, alu_src, mem_write, result_src,
    // branch_op, alu_op, width_op, pc_base
    always_comb begin
        illegal_o = 1'b0;
        case (op_i)
            `OP_R: ctrl_o = '{
                1'b1, decode_pkg::IMM_NONE, 1'b0, 1'b0, decode_pkg::RES_ALU,
                decode_pkg::BR_NONE, decode_pkg::ALU_OP_PROCESS, 1'b0, decode_pkg::PC_BASE_NA
            };
            `OP_I_ALU: ctrl_o = '{
                1'b1, decode_pkg::IMM_I, 1'b1, 1'b0, decode_pkg::RES_ALU,
                decode_pkg::BR_NONE, decode_pkg::ALU_OP_PROCESS, 1'b0, decode_pkg::PC_BASE_NA
            };
            // Width follows funct3 for memory accesses
            `OP_LOAD: ctrl_o = '{
                1'b1, decode_pkg::IMM_I, 1'b1, 1'b0, decode_pkg::RES_MEM,
                decode_pkg::BR_NONE, decode_pkg::ALU_OP_ADD, 1'b1, decode_pkg::PC_BASE_NA
            };
            `OP_STORE: ctrl_o = '{
                1'b0, decode_pkg::IMM_S, 1'b1, 1'b1, decode_pkg::RES_ALU,
                decode_pkg::BR_NONE, decode_pkg::ALU_OP_ADD, 1'b1, decode_pkg::PC_BASE_NA
            };
            // Compare by subtraction, target from PC
            `OP_BRANCH: ctrl_o = '{
                1'b0, decode_pkg::IMM_B, 1'b0, 1'b0, decode_pkg::RES_ALU,
                decode_pkg::BR_BRANCH, decode_pkg::ALU_OP_SUB, 1'b0, decode_pkg::PC_BASE_PC
            };
            `OP_JAL: ctrl_o = '{
                1'b1, decode_pkg::IMM_J, 1'b0, 1'b0, decode_pkg::RES_PC_PLUS4,
                decode_pkg::BR_JUMP, decode_pkg::ALU_OP_NA, 1'b0, decode_pkg::PC_BASE_PC
            };
            // Target base is rs1 rather than PC
            `OP_JALR: ctrl_o = '{
                1'b1, decode_pkg::IMM_I, 1'b0, 1'b0, decode_pkg::RES_PC_PLUS4,
                decode_pkg::BR_JUMP, decode_pkg::ALU_OP_NA, 1'b0, decode_pkg::PC_BASE_SRCA
            };
            `OP_LUI: ctrl_o = '{
                1'b1, decode_pkg::IMM_U, 1'b0, 1'b0, decode_pkg::RES_IMM,
                decode_pkg::BR_NONE, decode_pkg::ALU_OP_NA, 1'b0, decode_pkg::PC_BASE_NA
            };
            `OP_AUIPC: ctrl_o = '{
                1'b1, decode_pkg::IMM_U, 1'b0, 1'b0, decode_pkg::RES_PC_TARGET,
                decode_pkg::BR_NONE, decode_pkg::ALU_OP_NA, 1'b0, decode_pkg::PC_BASE_PC
            };
            // System, fence and anything unknown
            default: begin
                ctrl_o    = '0;
                illegal_o = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire
